//--- common/rvCorePkg.sv
package rvCorePkg;

	// ALU functions, the last six only compare for branches
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE,
		ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} aluOp_t;

	// immediate layouts
	typedef enum logic [2:0] {
		IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_J, IMM_U
	} immKind_t;

	// writeback value source
	typedef enum logic [1:0] {
		RES_ALU, RES_MEM, RES_PC4
	} resultSrc_t;

	// operand bypass source in execute
	typedef enum logic [1:0] {
		FWD_NONE, FWD_FROM_WB, FWD_FROM_MEM
	} fwdSel_t;

endpackage

//--- common/rvIsaPkg.sv
`include "rv_consts.svh"

package rvIsaPkg;

	// data or address value
	typedef logic [`XLEN-1:0] word_t;

	typedef logic [31:0] instr_t;

	typedef logic [4:0] regIdx_t;

	typedef logic [2:0] funct3_t;

	// major opcodes handled by the core
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_LUI    = 7'b0110111
	} opcode_t;

endpackage

//--- common/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path width
`define XLEN 32

// architectural integer registers
`define REG_COUNT 32

// data memory depth in words
`define DMEM_WORDS 64

`define RESET_PC 32'h0000_0000

`endif

//--- decode/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
	input  rvIsaPkg::instr_t instrD,
	output logic regWrite,
	output logic memWrite,
	output logic branch,
	output logic jump,
	output logic aluSrcImm,
	output logic aluAZero,
	output rvCorePkg::resultSrc_t resultSrc,
	output rvCorePkg::aluOp_t aluOp,
	output rvIsaPkg::word_t imm,
	output rvIsaPkg::regIdx_t rs1,
	output rvIsaPkg::regIdx_t rs2,
	output rvIsaPkg::regIdx_t rd
);
	rvIsaPkg::opcode_t opcode;
	rvIsaPkg::funct3_t funct3;
	rvCorePkg::immKind_t immKind;
	logic funct7b5;
	logic useRs1;
	logic useRs2;

	assign opcode = rvIsaPkg::opcode_t'(instrD[6:0]);
	assign funct3 = instrD[14:12];
	assign funct7b5 = instrD[30];

	// unused fields read as x0 so they never cause a stall or a bypass
	assign rs1 = useRs1 ? instrD[19:15] : '0;
	assign rs2 = useRs2 ? instrD[24:20] : '0;
	assign rd = regWrite ? instrD[11:7] : '0;

	// main control, anything unknown (including all zeros) is a bubble
	always_comb begin
		regWrite = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		aluSrcImm = 1'b0;
		aluAZero = 1'b0;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		resultSrc = rvCorePkg::RES_ALU;
		immKind = rvCorePkg::IMM_I;
		case (opcode)
			rvIsaPkg::OPC_LOAD: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				useRs1 = 1'b1;
				resultSrc = rvCorePkg::RES_MEM;
			end
			rvIsaPkg::OPC_STORE: begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				immKind = rvCorePkg::IMM_S;
			end
			rvIsaPkg::OPC_OP: begin
				regWrite = 1'b1;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
			end
			rvIsaPkg::OPC_OP_IMM: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				useRs1 = 1'b1;
				// funct3 001 and 101 are the shifts
				if (funct3[1:0] == 2'b01) begin
					immKind = rvCorePkg::IMM_SHAMT;
				end
			end
			rvIsaPkg::OPC_BRANCH: begin
				branch = 1'b1;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				immKind = rvCorePkg::IMM_B;
			end
			rvIsaPkg::OPC_JAL: begin
				regWrite = 1'b1;
				jump = 1'b1;
				resultSrc = rvCorePkg::RES_PC4;
				immKind = rvCorePkg::IMM_J;
			end
			rvIsaPkg::OPC_LUI: begin
				// zero plus the upper immediate
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluAZero = 1'b1;
				immKind = rvCorePkg::IMM_U;
			end
			default: begin
			end
		endcase
	end

	// ALU function
	always_comb begin
		aluOp = rvCorePkg::ALU_ADD;
		if (opcode == rvIsaPkg::OPC_BRANCH) begin
			case (funct3)
				3'b001: aluOp = rvCorePkg::ALU_BNE;
				3'b100: aluOp = rvCorePkg::ALU_BLT;
				3'b101: aluOp = rvCorePkg::ALU_BGE;
				3'b110: aluOp = rvCorePkg::ALU_BLTU;
				3'b111: aluOp = rvCorePkg::ALU_BGEU;
				default: aluOp = rvCorePkg::ALU_BEQ;
			endcase
		end else if (opcode == rvIsaPkg::OPC_OP || opcode == rvIsaPkg::OPC_OP_IMM) begin
			case (funct3)
				3'b000: begin
					// no SUBI, bit 30 of ADDI is immediate
					if (opcode == rvIsaPkg::OPC_OP && funct7b5) begin
						aluOp = rvCorePkg::ALU_SUB;
					end
				end
				3'b001: aluOp = rvCorePkg::ALU_SLL;
				3'b010: aluOp = rvCorePkg::ALU_SLT;
				3'b011: aluOp = rvCorePkg::ALU_SLTU;
				3'b100: aluOp = rvCorePkg::ALU_XOR;
				3'b101: aluOp = funct7b5 ? rvCorePkg::ALU_SRA : rvCorePkg::ALU_SRL;
				3'b110: aluOp = rvCorePkg::ALU_OR;
				default: aluOp = rvCorePkg::ALU_AND;
			endcase
		end
	end

	// immediate extension
	always_comb begin
		case (immKind)
			rvCorePkg::IMM_I: imm = {{20{instrD[31]}}, instrD[31:20]};
			rvCorePkg::IMM_SHAMT: imm = {27'd0, instrD[24:20]};
			rvCorePkg::IMM_S: imm = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
			rvCorePkg::IMM_B: begin
				imm = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
			end
			rvCorePkg::IMM_J: begin
				imm = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
			end
			rvCorePkg::IMM_U: imm = {instrD[31:12], 12'd0};
			default: imm = '0;
		endcase
	end

endmodule

//--- decode/regFile.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module regFile (
	input  logic clk,
	input  logic rst,
	input  logic we,
	input  rvIsaPkg::regIdx_t ra1,
	input  rvIsaPkg::regIdx_t ra2,
	input  rvIsaPkg::regIdx_t wa,
	input  rvIsaPkg::word_t wd,
	output rvIsaPkg::word_t rd1,
	output rvIsaPkg::word_t rd2
);
	rvIsaPkg::word_t regs [`REG_COUNT];

	// falling edge write, so decode sees writeback data in the same cycle
	always_ff @(negedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// x0 is hardwired
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

//--- hw/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
	input  rvCorePkg::aluOp_t aluOp,
	input  rvIsaPkg::word_t srcA,
	input  rvIsaPkg::word_t srcB,
	output rvIsaPkg::word_t result,
	output logic branchTaken
);
	logic equal;
	logic lessSigned;
	logic lessUnsigned;
	logic [4:0] shamt;

	// compares shared by SLT(U) and the branches
	assign equal = (srcA == srcB);
	assign lessSigned = ($signed(srcA) < $signed(srcB));
	assign lessUnsigned = (srcA < srcB);
	assign shamt = srcB[4:0];

	always_comb begin
		result = '0;
		branchTaken = 1'b0;
		case (aluOp)
			rvCorePkg::ALU_ADD: result = srcA + srcB;
			rvCorePkg::ALU_SUB: result = srcA - srcB;
			rvCorePkg::ALU_AND: result = srcA & srcB;
			rvCorePkg::ALU_OR: result = srcA | srcB;
			rvCorePkg::ALU_XOR: result = srcA ^ srcB;
			rvCorePkg::ALU_SLL: result = srcA << shamt;
			rvCorePkg::ALU_SRL: result = srcA >> shamt;
			rvCorePkg::ALU_SRA: result = $signed(srcA) >>> shamt;
			rvCorePkg::ALU_SLT: result = rvIsaPkg::word_t'(lessSigned);
			rvCorePkg::ALU_SLTU: result = rvIsaPkg::word_t'(lessUnsigned);
			rvCorePkg::ALU_BEQ: branchTaken = equal;
			rvCorePkg::ALU_BNE: branchTaken = !equal;
			rvCorePkg::ALU_BLT: branchTaken = lessSigned;
			rvCorePkg::ALU_BGE: branchTaken = !lessSigned;
			rvCorePkg::ALU_BLTU: branchTaken = lessUnsigned;
			rvCorePkg::ALU_BGEU: branchTaken = !lessUnsigned;
			default: result = '0;
		endcase
	end

endmodule

//--- hw/fetchUnit.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module fetchUnit (
	input  logic clk,
	input  logic rst,
	input  logic stallF,
	input  logic stallD,
	input  logic flushD,
	input  logic redirect,
	input  rvIsaPkg::word_t target,
	input  rvIsaPkg::instr_t instr,
	output rvIsaPkg::word_t pc,
	output rvIsaPkg::instr_t instrD,
	output rvIsaPkg::word_t pcD,
	output rvIsaPkg::word_t pcPlus4D
);
	rvIsaPkg::word_t pcPlus4;

	assign pcPlus4 = pc + 32'd4;

	// program counter
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
		end else if (!stallF) begin
			pc <= redirect ? target : pcPlus4;
		end
	end

	// fetch/decode register, a zero word is a bubble
	always_ff @(posedge clk) begin
		if (rst || flushD) begin
			instrD <= '0;
			pcD <= '0;
			pcPlus4D <= '0;
		end else if (!stallD) begin
			instrD <= instr;
			pcD <= pc;
			pcPlus4D <= pcPlus4;
		end
	end

endmodule

//--- hw/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
	input  rvIsaPkg::regIdx_t rs1D,
	input  rvIsaPkg::regIdx_t rs2D,
	input  rvIsaPkg::regIdx_t rs1E,
	input  rvIsaPkg::regIdx_t rs2E,
	input  rvIsaPkg::regIdx_t rdE,
	input  rvIsaPkg::regIdx_t rdM,
	input  rvIsaPkg::regIdx_t rdW,
	input  logic loadE,
	input  logic regWriteM,
	input  logic regWriteW,
	input  logic redirect,
	output rvCorePkg::fwdSel_t fwdA,
	output rvCorePkg::fwdSel_t fwdB,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE
);
	logic loadUse;

	// memory stage is younger, so it wins over writeback
	always_comb begin
		fwdA = rvCorePkg::FWD_NONE;
		fwdB = rvCorePkg::FWD_NONE;
		if (rs1E != '0 && regWriteM && rs1E == rdM) begin
			fwdA = rvCorePkg::FWD_FROM_MEM;
		end else if (rs1E != '0 && regWriteW && rs1E == rdW) begin
			fwdA = rvCorePkg::FWD_FROM_WB;
		end
		if (rs2E != '0 && regWriteM && rs2E == rdM) begin
			fwdB = rvCorePkg::FWD_FROM_MEM;
		end else if (rs2E != '0 && regWriteW && rs2E == rdW) begin
			fwdB = rvCorePkg::FWD_FROM_WB;
		end
	end

	// load data only exists after memory, hold decode one cycle
	assign loadUse = loadE && rdE != '0 && (rdE == rs1D || rdE == rs2D);

	assign stallF = loadUse;
	assign stallD = loadUse;
	assign flushD = redirect;
	assign flushE = redirect || loadUse;

endmodule

//--- hw/rvPipeTop.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rvPipeTop (
	input  logic clk,
	input  logic rst,
	input  rvIsaPkg::instr_t instr,
	output rvIsaPkg::word_t pc,
	output rvIsaPkg::word_t dataAddr,
	output rvIsaPkg::word_t storeData,
	output logic memWrite
);
	localparam int DmemAw = $clog2(`DMEM_WORDS);

	// decode
	rvIsaPkg::instr_t instrD;
	rvIsaPkg::word_t pcD, pcPlus4D, immD, rd1D, rd2D;
	rvIsaPkg::regIdx_t rs1D, rs2D, rdD;
	logic regWriteD, memWriteD, branchD, jumpD, aluSrcImmD, aluAZeroD;
	rvCorePkg::resultSrc_t resultSrcD;
	rvCorePkg::aluOp_t aluOpD;

	// execute
	logic regWriteE, memWriteE, branchE, jumpE, aluSrcImmE, aluAZeroE;
	rvCorePkg::resultSrc_t resultSrcE;
	rvCorePkg::aluOp_t aluOpE;
	rvIsaPkg::word_t immE, rd1E, rd2E, pcE, pcPlus4E;
	rvIsaPkg::regIdx_t rs1E, rs2E, rdE;
	rvIsaPkg::word_t fwdValA, writeDataE, srcA, srcB, aluResultE, target;
	logic loadE, branchTakenE, redirect;

	// memory and writeback
	logic regWriteM, memWriteM, regWriteW;
	rvCorePkg::resultSrc_t resultSrcM, resultSrcW;
	rvIsaPkg::word_t aluResultM, writeDataM, pcPlus4M, resultM, readDataM;
	rvIsaPkg::word_t aluResultW, readDataW, pcPlus4W, resultW;
	rvIsaPkg::regIdx_t rdM, rdW;
	rvIsaPkg::word_t dmem [`DMEM_WORDS];

	logic stallF, stallD, flushD, flushE;
	rvCorePkg::fwdSel_t fwdA, fwdB;

	function automatic rvIsaPkg::word_t fwdMux(input rvCorePkg::fwdSel_t sel,
		input rvIsaPkg::word_t regVal, input rvIsaPkg::word_t fromMem,
		input rvIsaPkg::word_t fromWb);
		case (sel)
			rvCorePkg::FWD_FROM_MEM: return fromMem;
			rvCorePkg::FWD_FROM_WB: return fromWb;
			default: return regVal;
		endcase
	endfunction

	fetchUnit fetch (.*);

	instrDecoder decoder (
		.instrD(instrD),
		.regWrite(regWriteD), .memWrite(memWriteD), .branch(branchD), .jump(jumpD),
		.aluSrcImm(aluSrcImmD), .aluAZero(aluAZeroD), .resultSrc(resultSrcD),
		.aluOp(aluOpD), .imm(immD), .rs1(rs1D), .rs2(rs2D), .rd(rdD)
	);

	regFile regs (
		.clk(clk), .rst(rst), .we(regWriteW),
		.ra1(rs1D), .ra2(rs2D), .wa(rdW), .wd(resultW),
		.rd1(rd1D), .rd2(rd2D)
	);

	// decode/execute, a flush leaves a bubble
	always_ff @(posedge clk) begin
		if (rst || flushE) begin
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			branchE <= 1'b0;
			jumpE <= 1'b0;
			resultSrcE <= rvCorePkg::RES_ALU;
		end else begin
			regWriteE <= regWriteD;
			memWriteE <= memWriteD;
			branchE <= branchD;
			jumpE <= jumpD;
			resultSrcE <= resultSrcD;
		end
	end

	always_ff @(posedge clk) begin
		aluSrcImmE <= aluSrcImmD;
		aluAZeroE <= aluAZeroD;
		aluOpE <= aluOpD;
		immE <= immD;
		rd1E <= rd1D;
		rd2E <= rd2D;
		pcE <= pcD;
		pcPlus4E <= pcPlus4D;
		rs1E <= rs1D;
		rs2E <= rs2D;
		rdE <= rdD;
	end

	// execute
	assign loadE = (resultSrcE == rvCorePkg::RES_MEM);
	assign fwdValA = fwdMux(fwdA, rd1E, resultM, resultW);
	assign writeDataE = fwdMux(fwdB, rd2E, resultM, resultW);
	assign srcA = aluAZeroE ? '0 : fwdValA;
	assign srcB = aluSrcImmE ? immE : writeDataE;

	aluUnit alu (
		.aluOp(aluOpE), .srcA(srcA), .srcB(srcB),
		.result(aluResultE), .branchTaken(branchTakenE)
	);

	// branches and JAL are both pc relative
	assign target = pcE + immE;
	assign redirect = (branchE && branchTakenE) || jumpE;

	hazardUnit hazard (.*);

	// execute/memory
	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteM <= 1'b0;
			memWriteM <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			memWriteM <= memWriteE;
		end
	end

	always_ff @(posedge clk) begin
		resultSrcM <= resultSrcE;
		aluResultM <= aluResultE;
		writeDataM <= writeDataE;
		pcPlus4M <= pcPlus4E;
		rdM <= rdE;
	end

	// bypass value, a JAL here hands on its link address
	assign resultM = (resultSrcM == rvCorePkg::RES_PC4) ? pcPlus4M : aluResultM;

	// word addressed data memory
	assign readDataM = dmem[aluResultM[DmemAw+1:2]];

	always_ff @(posedge clk) begin
		if (memWriteM) begin
			dmem[aluResultM[DmemAw+1:2]] <= writeDataM;
		end
	end

	assign dataAddr = aluResultM;
	assign storeData = writeDataM;
	assign memWrite = memWriteM;

	// memory/writeback
	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteW <= 1'b0;
		end else begin
			regWriteW <= regWriteM;
		end
	end

	always_ff @(posedge clk) begin
		resultSrcW <= resultSrcM;
		aluResultW <= aluResultM;
		readDataW <= readDataM;
		pcPlus4W <= pcPlus4M;
		rdW <= rdM;
	end

	always_comb begin
		case (resultSrcW)
			rvCorePkg::RES_MEM: resultW = readDataW;
			rvCorePkg::RES_PC4: resultW = pcPlus4W;
			default: resultW = aluResultW;
		endcase
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f rvPipe.f --top-module rvPipeTb -o rvPipeSim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rvPipeSim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || grep -q "Finished with no errors" sim.log

//--- rvPipe.f
+incdir+common
common/rvIsaPkg.sv
common/rvCorePkg.sv
hw/fetchUnit.sv
decode/instrDecoder.sv
decode/regFile.sv
hw/aluUnit.sv
hw/hazardUnit.sv
hw/rvPipeTop.sv
verif/tbClock.sv
verif/rvPipe_assertions.sv
verif/rvPipeTb.sv

//--- verif/rvPipeTb.sv
`timescale 1ns/1ns

module rvPipeTb;
	logic clk;
	logic rst;
	rvIsaPkg::instr_t instr;
	rvIsaPkg::word_t pc;
	rvIsaPkg::word_t dataAddr;
	rvIsaPkg::word_t storeData;
	logic memWrite;

	rvIsaPkg::instr_t rom [512];
	int progLen;
	int nextAddr;
	integer seed;
	bit buildDone;
	string curTest;
	rvIsaPkg::word_t expAddr[$];
	rvIsaPkg::word_t expData[$];
	string expName[$];

	tbClock clkGen (.clk(clk), .rst(rst));

	rvPipeTop DUT (
		.clk(clk), .rst(rst), .instr(instr), .pc(pc),
		.dataAddr(dataAddr), .storeData(storeData), .memWrite(memWrite)
	);

	bind rvPipeTop rvPipe_assertions protocolChk (
		.clk(clk), .rst(rst), .pc(pc), .dataAddr(dataAddr),
		.memWrite(memWrite), .redirect(redirect)
	);

	// same-cycle ROM read that returns zero past the end
	assign instr = (pc[31:11] == '0) ? rom[pc[10:2]] : '0;

	function automatic rvIsaPkg::instr_t encR(logic [6:0] f7, logic [4:0] rs2,
		logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rvIsaPkg::instr_t encI(logic [11:0] imm, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rvIsaPkg::instr_t encS(logic [11:0] imm, logic [4:0] rs2,
		logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic rvIsaPkg::instr_t encB(logic [12:0] off, logic [4:0] rs2,
		logic [4:0] rs1, logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic rvIsaPkg::instr_t encJ(logic [20:0] off, logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// branch outcome by the RV32I definition
	function automatic bit branchCond(logic [2:0] f3, rvIsaPkg::word_t a,
		rvIsaPkg::word_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic emit(rvIsaPkg::instr_t word);
		rom[progLen] = word;
		progLen++;
	endtask

	// upper part of LUI rounded for the sign of the ADDI part
	task automatic loadConst(logic [4:0] rd, rvIsaPkg::word_t value);
		rvIsaPkg::word_t hi;
		hi = value + 32'h800;
		emit({hi[31:12], rd, 7'b0110111});
		emit(encI(value[11:0], rd, 3'b000, rd, 7'b0010011));
	endtask

	task automatic storeTo(logic [4:0] rs, rvIsaPkg::word_t value, bit expected);
		emit(encS(12'(nextAddr), rs, 5'd0));
		if (expected) begin
			expAddr.push_back(32'(nextAddr));
			expData.push_back(value);
			expName.push_back(curTest);
		end
		nextAddr = (nextAddr + 4) % 240;
	endtask

	task automatic rOp(logic [6:0] f7, logic [2:0] f3, rvIsaPkg::word_t value);
		emit(encR(f7, 5'd2, 5'd1, f3, 5'd3));
		storeTo(5'd3, value, 1'b1);
	endtask

	task automatic iOp(logic [11:0] imm, logic [2:0] f3, rvIsaPkg::word_t value);
		emit(encI(imm, 5'd1, f3, 5'd4, 7'b0010011));
		storeTo(5'd4, value, 1'b1);
	endtask

	task automatic aluTests(rvIsaPkg::word_t a, rvIsaPkg::word_t b);
		logic [11:0] imm;
		logic [4:0] sh;
		rvIsaPkg::word_t iv;
		imm = 12'($random(seed));
		sh = 5'($random(seed));
		iv = {{20{imm[11]}}, imm};
		curTest = "alu";
		loadConst(5'd1, a);
		loadConst(5'd2, b);
		rOp(7'h00, 3'b000, a + b);
		rOp(7'h20, 3'b000, a - b);
		rOp(7'h00, 3'b001, a << b[4:0]);
		rOp(7'h00, 3'b010, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		rOp(7'h00, 3'b011, (a < b) ? 32'd1 : 32'd0);
		rOp(7'h00, 3'b100, a ^ b);
		rOp(7'h00, 3'b101, a >> b[4:0]);
		rOp(7'h20, 3'b101, rvIsaPkg::word_t'($signed(a) >>> b[4:0]));
		rOp(7'h00, 3'b110, a | b);
		rOp(7'h00, 3'b111, a & b);
		iOp(imm, 3'b000, a + iv);
		iOp({7'h00, sh}, 3'b001, a << sh);
		iOp(imm, 3'b010, ($signed(a) < $signed(iv)) ? 32'd1 : 32'd0);
		iOp(imm, 3'b011, (a < iv) ? 32'd1 : 32'd0);
		iOp(imm, 3'b100, a ^ iv);
		iOp({7'h00, sh}, 3'b101, a >> sh);
		iOp({7'h20, sh}, 3'b101, rvIsaPkg::word_t'($signed(a) >>> sh));
		iOp(imm, 3'b110, a | iv);
		iOp(imm, 3'b111, a & iv);
	endtask

	task automatic branchTests(rvIsaPkg::word_t a, rvIsaPkg::word_t b);
		logic [2:0] codes [6];
		bit taken;
		codes = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		curTest = "branch";
		loadConst(5'd1, a);
		loadConst(5'd2, b);
		foreach (codes[i]) begin
			taken = branchCond(codes[i], a, b);
			// offset 12 skips both marker stores
			emit(encB(13'd12, 5'd2, 5'd1, codes[i]));
			storeTo(5'd1, a, !taken);
			storeTo(5'd2, b, !taken);
		end
	endtask

	task automatic buildProgram();
		rvIsaPkg::word_t v;
		rvIsaPkg::word_t k;
		logic [19:0] upper;
		logic [11:0] low;
		int jalPc;
		foreach (rom[i]) begin
			rom[i] = '0;
		end
		aluTests($random(seed), $random(seed));
		aluTests(32'hffff_fffb, 32'd3);
		curTest = "lui";
		upper = 20'($random(seed));
		low = 12'($random(seed));
		emit({upper, 5'd5, 7'b0110111});
		emit(encI(low, 5'd5, 3'b000, 5'd5, 7'b0010011));
		storeTo(5'd5, {upper, 12'd0} + {{20{low[11]}}, low}, 1'b1);
		curTest = "forward";
		low = 12'($random(seed));
		v = {{20{low[11]}}, low};
		emit(encI(low, 5'd0, 3'b000, 5'd6, 7'b0010011));
		emit(encR(7'h00, 5'd6, 5'd6, 3'b000, 5'd7));
		emit(encR(7'h00, 5'd6, 5'd7, 3'b000, 5'd8));
		storeTo(5'd8, v * 3, 1'b1);
		emit(encI(12'd5, 5'd0, 3'b000, 5'd0, 7'b0010011));
		storeTo(5'd0, 32'd0, 1'b1);
		curTest = "loadUse";
		v = $random(seed);
		k = $random(seed);
		loadConst(5'd10, v);
		loadConst(5'd13, k);
		emit(encS(12'd252, 5'd10, 5'd0));
		expAddr.push_back(32'd252);
		expData.push_back(v);
		expName.push_back(curTest);
		emit(encI(12'd252, 5'd0, 3'b010, 5'd11, 7'b0000011));
		emit(encR(7'h00, 5'd13, 5'd11, 3'b000, 5'd12));
		storeTo(5'd12, v + k, 1'b1);
		branchTests(32'hffff_ffff, 32'd1);
		branchTests(32'd1, 32'd1);
		branchTests(32'd1, 32'hffff_ffff);
		curTest = "jal";
		jalPc = progLen * 4;
		// jump over three stores to the fourth word on
		emit(encJ(21'd16, 5'd15));
		storeTo(5'd0, 32'd0, 1'b0);
		storeTo(5'd0, 32'd0, 1'b0);
		storeTo(5'd0, 32'd0, 1'b0);
		storeTo(5'd15, 32'(jalPc + 4), 1'b1);
	endtask

	// compare each store with the head of the expected list
	always @(negedge clk) begin
		if (!rst && memWrite) begin
			if (expAddr.size() == 0) begin
				$display("store to %h seen after all expected stores", dataAddr);
				$display("Finished with errors");
				$fatal(1);
			end else begin
				storeCheck: assert (dataAddr == expAddr[0] && storeData == expData[0])
				else begin
					$display("Fail %s: expected %h at %h, actual %h at %h", expName[0],
						expData[0], expAddr[0], storeData, dataAddr);
					$display("Finished with errors");
					$fatal(1);
				end
				void'(expAddr.pop_front());
				void'(expData.pop_front());
				void'(expName.pop_front());
			end
		end
	end

	// watchdog allows 40 cycles per program word
	initial begin
		wait (buildDone);
		#(progLen * 40 * 20);
		$display("timeout, the expected stores did not all arrive");
		$display("Finished with errors");
		$fatal(1);
	end

	initial begin
		seed = 32'h1b769bfc;
		progLen = 0;
		nextAddr = 0;
		buildDone = 1'b0;
		buildProgram();
		buildDone = 1'b1;
		@(negedge clk);
		while (rst) @(negedge clk);
		while (expAddr.size() != 0) @(negedge clk);
		// let the bubbles drain to catch a stray store
		repeat (10) @(negedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- verif/rvPipe_assertions.sv
`timescale 1ns/1ns

module rvPipe_assertions (
	input logic clk,
	input logic rst,
	input rvIsaPkg::word_t pc,
	input rvIsaPkg::word_t dataAddr,
	input logic memWrite,
	input logic redirect
);
	// no store straight out of reset
	memWriteQuiet: assert property (@(posedge clk) $past(rst) |-> !memWrite)
		else $error("store strobe seen during or right after reset");

	pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("fetch address not word aligned");

	// hold on stall, step by four, or jump after a redirect
	pcStep: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> (pc == $past(pc) || pc == $past(pc) + 32'd4 || $past(redirect)))
		else $error("pc changed without a branch or jump");

	storeAligned: assert property (@(posedge clk) disable iff (rst)
		memWrite |-> dataAddr[1:0] == 2'b00)
		else $error("store address not word aligned");

endmodule

//--- verif/tbClock.sv
`timescale 1ns/1ns

module tbClock (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held for two rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule
